/* filelist.f */
source/dcache_geom_pkg.sv
source/dcache_ctrl_pkg.sv
source/dcache_lookup_if.sv
source/dcache_sram.sv
source/dcache_req_decode.sv
source/dcache_ctrl.sv
source/dcache_resp.sv
source/dcache_top.sv
tb/dcache_tb_clk.sv
tb/dcache_tb_check.sv
tb/dcache_tb.sv

/* source/dcache_ctrl.sv */
// hit/miss controller FSM
// per-set valid, dirty and recency bits for two ways
// victim choice, write-back and refill strobes
// array write enables and response select

`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter int INDEX_W = dcache_geom_pkg::INDEX_W_DEFAULT,
    parameter int TAG_W   = dcache_geom_pkg::TAG_W_DEFAULT
) (
    input  wire logic                               clk,
    input  wire logic                               rst,

    dcache_lookup_if.ctrl                           lk,

    input  wire logic [TAG_W-1:0]                   tag0_i,
    input  wire logic [TAG_W-1:0]                   tag1_i,
    output logic                                    tag_we0_o,
    output logic                                    tag_we1_o,
    output logic                                    data_we0_o,
    output logic                                    data_we1_o,
    output logic [INDEX_W-1:0]                      wr_index_o,
    output logic [TAG_W-1:0]                        wr_tag_o,

    output dcache_ctrl_pkg::resp_sel_t              sel_o,
    output logic                                    fire_o,
    input  dcache_geom_pkg::word_t                  victim_data_i,

    output logic [dcache_geom_pkg::ADDR_W-1:0]      mem_addr_o,
    output dcache_geom_pkg::word_t                  mem_wdata_o,
    output logic                                    mem_rd_o,
    output logic                                    mem_wr_o,
    input  wire logic                               mem_ok_i
);

    localparam int SETS = 2 ** INDEX_W;

    dcache_ctrl_pkg::ctrl_state_t state_q;
    dcache_ctrl_pkg::ctrl_state_t state_d;

    logic [SETS-1:0]  valid_q [2];
    logic [SETS-1:0]  dirty_q [2];
    // names the way to evict next
    logic [SETS-1:0]  recent_q;
    logic             victim_q;

    logic             hit0;
    logic             hit1;
    logic             hit;
    logic             victim_way;
    logic             upd_way;
    logic [TAG_W-1:0] victim_tag;

    assign hit0 = valid_q[0][lk.index] && (tag0_i == lk.tag);
    assign hit1 = valid_q[1][lk.index] && (tag1_i == lk.tag);
    assign hit  = hit0 || hit1;

    // empty way first, way 0 before way 1
    always_comb begin
        if (!valid_q[0][lk.index]) begin
            victim_way = 1'b0;
        end else if (!valid_q[1][lk.index]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = recent_q[lk.index];
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_ctrl_pkg::IDLE: begin
                if (lk.req_valid) begin
                    state_d = dcache_ctrl_pkg::LOOKUP;
                end
            end
            dcache_ctrl_pkg::LOOKUP: begin
                if (hit) begin
                    state_d = dcache_ctrl_pkg::HIT;
                end else if (dirty_q[victim_way][lk.index]) begin
                    state_d = dcache_ctrl_pkg::WBACK;
                end else begin
                    state_d = dcache_ctrl_pkg::REFILL;
                end
            end
            dcache_ctrl_pkg::WBACK: begin
                if (mem_ok_i) begin
                    state_d = dcache_ctrl_pkg::REFILL;
                end
            end
            dcache_ctrl_pkg::REFILL: begin
                if (mem_ok_i) begin
                    state_d = dcache_ctrl_pkg::FILL_WRITE;
                end
            end
            // fill done, retire through the same quiet cycle as a hit
            dcache_ctrl_pkg::FILL_WRITE: state_d = dcache_ctrl_pkg::HIT;
            default: state_d = dcache_ctrl_pkg::IDLE;
        endcase
    end

    assign fire_o  = ((state_q == dcache_ctrl_pkg::LOOKUP) && hit)
                   || (state_q == dcache_ctrl_pkg::FILL_WRITE);
    assign upd_way = (state_q == dcache_ctrl_pkg::LOOKUP) ? hit1 : victim_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q  <= dcache_ctrl_pkg::IDLE;
            valid_q  <= '{default: '0};
            dirty_q  <= '{default: '0};
            recent_q <= '0;
            victim_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == dcache_ctrl_pkg::LOOKUP) begin
                victim_q <= victim_way;
            end
            if (fire_o) begin
                valid_q[upd_way][lk.index] <= 1'b1;
                // a load hit keeps the line's dirty bit, a fill starts clean
                dirty_q[upd_way][lk.index] <= lk.is_store
                    || ((state_q == dcache_ctrl_pkg::LOOKUP) && dirty_q[upd_way][lk.index]);
                recent_q[lk.index] <= ~upd_way;
            end
        end
    end

    assign lk.req_done = fire_o;

    assign tag_we0_o  = (state_q == dcache_ctrl_pkg::FILL_WRITE) && !victim_q;
    assign tag_we1_o  = (state_q == dcache_ctrl_pkg::FILL_WRITE) && victim_q;
    assign data_we0_o = tag_we0_o || ((state_q == dcache_ctrl_pkg::LOOKUP) && hit0 && lk.is_store);
    assign data_we1_o = tag_we1_o || ((state_q == dcache_ctrl_pkg::LOOKUP) && hit1 && lk.is_store);
    assign wr_index_o = lk.index;
    assign wr_tag_o   = lk.tag;

    always_comb begin
        case (state_q)
            dcache_ctrl_pkg::LOOKUP:
                sel_o = hit1 ? dcache_ctrl_pkg::WAY1 : dcache_ctrl_pkg::WAY0;
            dcache_ctrl_pkg::WBACK:
                sel_o = victim_q ? dcache_ctrl_pkg::WAY1 : dcache_ctrl_pkg::WAY0;
            dcache_ctrl_pkg::FILL_WRITE:
                sel_o = dcache_ctrl_pkg::MEM;
            default:
                sel_o = dcache_ctrl_pkg::WAY0;
        endcase
    end

    // the victim's own line address goes out on write-back
    assign victim_tag = victim_q ? tag1_i : tag0_i;

    always_comb begin
        if (state_q == dcache_ctrl_pkg::WBACK) begin
            mem_addr_o = {victim_tag, lk.index, {dcache_geom_pkg::OFFSET_W{1'b0}}};
        end else begin
            mem_addr_o = {lk.tag, lk.index, {dcache_geom_pkg::OFFSET_W{1'b0}}};
        end
    end

    assign mem_wdata_o = victim_data_i;
    assign mem_wr_o    = (state_q == dcache_ctrl_pkg::WBACK);
    assign mem_rd_o    = (state_q == dcache_ctrl_pkg::REFILL);

    assert property (@(posedge clk) disable iff (!rst) !(mem_rd_o && mem_wr_o));

    // a waiting strobe keeps its address until the memory answers
    assert property (@(posedge clk) disable iff (!rst)
        (mem_rd_o || mem_wr_o) && !mem_ok_i |=> (mem_rd_o || mem_wr_o) && $stable(mem_addr_o));

endmodule

`default_nettype wire

/* source/dcache_ctrl_pkg.sv */
// data cache controller encodings
// controller FSM states
// response data source select

`default_nettype none

package dcache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT,
        WBACK,
        REFILL,
        FILL_WRITE
    } ctrl_state_t;

    // which word feeds the response and the array write
    typedef enum logic [1:0] {
        WAY0,
        WAY1,
        MEM
    } resp_sel_t;

endpackage

`default_nettype wire

/* source/dcache_geom_pkg.sv */
// data cache geometry
// address, word and byte-mask widths
// default set index and tag widths
// word and byte-mask types

`default_nettype none

package dcache_geom_pkg;

    localparam int ADDR_W   = 64;
    localparam int DATA_W   = 64;
    localparam int MASK_W   = DATA_W / 8;
    localparam int OFFSET_W = 3;

    // 64 sets of one word each
    localparam int INDEX_W_DEFAULT = 6;
    localparam int TAG_W_DEFAULT   = ADDR_W - INDEX_W_DEFAULT - OFFSET_W;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [MASK_W-1:0] mask_t;

endpackage

`default_nettype wire

/* source/dcache_lookup_if.sv */
// captured core request, decode to controller
// completion pulse back from the controller

`timescale 1ns/1ps
`default_nettype none

interface dcache_lookup_if #(
    parameter int INDEX_W = dcache_geom_pkg::INDEX_W_DEFAULT,
    parameter int TAG_W   = dcache_geom_pkg::TAG_W_DEFAULT
) ();

    logic                  req_valid;
    logic                  is_store;
    logic [TAG_W-1:0]      tag;
    logic [INDEX_W-1:0]    index;
    dcache_geom_pkg::word_t wdata;
    dcache_geom_pkg::mask_t mask;
    logic                  req_done;

    modport decode (output req_valid, is_store, tag, index, wdata, mask, input req_done);
    modport ctrl (input req_valid, is_store, tag, index, wdata, mask, output req_done);

endinterface

`default_nettype wire

/* source/dcache_req_decode.sv */
// core request capture
// address split into tag and set index
// busy flag against recapture of a retiring request

`timescale 1ns/1ps
`default_nettype none

module dcache_req_decode #(
    parameter int INDEX_W = dcache_geom_pkg::INDEX_W_DEFAULT,
    parameter int TAG_W   = dcache_geom_pkg::TAG_W_DEFAULT
) (
    input  wire logic                               clk,
    input  wire logic                               rst,

    input  wire logic                               mem_rd_i,
    input  wire logic                               mem_wr_i,
    input  wire logic [dcache_geom_pkg::ADDR_W-1:0] addr_i,
    input  dcache_geom_pkg::word_t                  wdata_i,
    input  dcache_geom_pkg::mask_t                  mask_i,

    dcache_lookup_if.decode                         lk
);

    logic                   capture;
    logic                   busy_q;
    logic                   valid_q;
    logic                   done_seen_q;
    logic                   is_store_q;
    logic [TAG_W-1:0]       tag_q;
    logic [INDEX_W-1:0]     index_q;
    dcache_geom_pkg::word_t wdata_q;
    dcache_geom_pkg::mask_t mask_q;

    assign capture = (mem_rd_i || mem_wr_i) && !busy_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy_q      <= 1'b0;
            valid_q     <= 1'b0;
            done_seen_q <= 1'b0;
        end else begin
            done_seen_q <= lk.req_done;
            // busy outlives valid by one cycle, the core drops its request then
            if (done_seen_q) begin
                busy_q <= 1'b0;
            end
            if (lk.req_done) begin
                valid_q <= 1'b0;
            end
            if (capture) begin
                busy_q  <= 1'b1;
                valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            is_store_q <= mem_wr_i;
            tag_q      <= addr_i[dcache_geom_pkg::ADDR_W-1 -: TAG_W];
            index_q    <= addr_i[dcache_geom_pkg::OFFSET_W +: INDEX_W];
            wdata_q    <= wdata_i;
            // loads merge nothing
            mask_q     <= mem_wr_i ? mask_i : '0;
        end
    end

    assign lk.req_valid = valid_q;
    assign lk.is_store  = is_store_q;
    assign lk.tag       = tag_q;
    assign lk.index     = index_q;
    assign lk.wdata     = wdata_q;
    assign lk.mask      = mask_q;

    // the edge after completion must not pick the old request up again
    assert property (@(posedge clk) disable iff (!rst) lk.req_done |=> !capture);

endmodule

`default_nettype wire

/* source/dcache_resp.sv */
// response path
// source word select, store byte merge
// registered load data and done pulse, victim word for write-back

`timescale 1ns/1ps
`default_nettype none

module dcache_resp (
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  dcache_ctrl_pkg::resp_sel_t sel_i,
    input  wire logic                  fire_i,
    input  dcache_geom_pkg::word_t     way0_data_i,
    input  dcache_geom_pkg::word_t     way1_data_i,
    input  dcache_geom_pkg::word_t     mem_rdata_i,
    input  dcache_geom_pkg::word_t     wdata_i,
    input  dcache_geom_pkg::mask_t     mask_i,

    output dcache_geom_pkg::word_t     merged_o,
    output dcache_geom_pkg::word_t     victim_data_o,
    output dcache_geom_pkg::word_t     rdata_o,
    output logic                       done_o
);

    dcache_geom_pkg::word_t src;
    dcache_geom_pkg::word_t fill_q;

    // refill word is used the cycle after mem_ok_i
    always_ff @(posedge clk) begin
        fill_q <= mem_rdata_i;
    end

    always_comb begin
        case (sel_i)
            dcache_ctrl_pkg::WAY0: src = way0_data_i;
            dcache_ctrl_pkg::WAY1: src = way1_data_i;
            default:               src = fill_q;
        endcase
    end

    always_comb begin
        for (int b = 0; b < dcache_geom_pkg::MASK_W; b++) begin
            merged_o[8*b +: 8] = mask_i[b] ? wdata_i[8*b +: 8] : src[8*b +: 8];
        end
    end

    assign victim_data_o = (sel_i == dcache_ctrl_pkg::WAY1) ? way1_data_i : way0_data_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            done_o  <= 1'b0;
            rdata_o <= '0;
        end else begin
            done_o <= fire_i;
            if (fire_i) begin
                rdata_o <= merged_o;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst) done_o |=> !done_o);

endmodule

`default_nettype wire

/* source/dcache_sram.sv */
// storage array for tags or data words
// synchronous read, whole-entry write

`timescale 1ns/1ps
`default_nettype none

module dcache_sram #(
    parameter type entry_t = dcache_geom_pkg::word_t,
    parameter int  INDEX_W = dcache_geom_pkg::INDEX_W_DEFAULT
) (
    input  wire logic               clk,

    input  wire logic [INDEX_W-1:0] rd_index_i,
    output entry_t                  rdata_o,

    input  wire logic               we_i,
    input  wire logic [INDEX_W-1:0] wr_index_i,
    input  entry_t                  wdata_i
);

    localparam int DEPTH = 2 ** INDEX_W;

    entry_t mem_q [DEPTH];

    // read returns the old entry when read and write hit the same index
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[wr_index_i] <= wdata_i;
        end
        rdata_o <= mem_q[rd_index_i];
    end

endmodule

`default_nettype wire

/* source/dcache_top.sv */
// two-way write-back data cache, top level
// request decode, controller, response path
// tag and data arrays for both ways

`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int INDEX_W = dcache_geom_pkg::INDEX_W_DEFAULT
) (
    input  wire logic                               clk,
    input  wire logic                               rst,

    // core side
    input  wire logic                               mem_rd_i,
    input  wire logic                               mem_wr_i,
    input  wire logic [dcache_geom_pkg::ADDR_W-1:0] addr_i,
    input  dcache_geom_pkg::word_t                  wdata_i,
    input  dcache_geom_pkg::mask_t                  mask_i,
    output dcache_geom_pkg::word_t                  rdata_o,
    output logic                                    done_o,

    // memory side
    output logic                                    mem_rd_o,
    output logic                                    mem_wr_o,
    output logic [dcache_geom_pkg::ADDR_W-1:0]      mem_addr_o,
    output dcache_geom_pkg::word_t                  mem_wdata_o,
    input  dcache_geom_pkg::word_t                  mem_rdata_i,
    input  wire logic                               mem_ok_i
);

    localparam int TAG_W = dcache_geom_pkg::ADDR_W - INDEX_W - dcache_geom_pkg::OFFSET_W;

    dcache_lookup_if #(.INDEX_W(INDEX_W), .TAG_W(TAG_W)) lk ();

    logic [TAG_W-1:0]           tag0;
    logic [TAG_W-1:0]           tag1;
    dcache_geom_pkg::word_t     data0;
    dcache_geom_pkg::word_t     data1;
    logic                       tag_we0;
    logic                       tag_we1;
    logic                       data_we0;
    logic                       data_we1;
    logic [INDEX_W-1:0]         wr_index;
    logic [TAG_W-1:0]           wr_tag;
    dcache_ctrl_pkg::resp_sel_t sel;
    logic                       fire;
    dcache_geom_pkg::word_t     merged;
    dcache_geom_pkg::word_t     victim_data;

    dcache_req_decode #(.INDEX_W(INDEX_W), .TAG_W(TAG_W)) i_decode (
        .clk, .rst, .mem_rd_i, .mem_wr_i, .addr_i, .wdata_i, .mask_i,
        .lk (lk.decode)
    );

    dcache_ctrl #(.INDEX_W(INDEX_W), .TAG_W(TAG_W)) i_ctrl (
        .clk, .rst,
        .lk            (lk.ctrl),
        .tag0_i        (tag0),
        .tag1_i        (tag1),
        .tag_we0_o     (tag_we0),
        .tag_we1_o     (tag_we1),
        .data_we0_o    (data_we0),
        .data_we1_o    (data_we1),
        .wr_index_o    (wr_index),
        .wr_tag_o      (wr_tag),
        .sel_o         (sel),
        .fire_o        (fire),
        .victim_data_i (victim_data),
        .mem_addr_o, .mem_wdata_o, .mem_rd_o, .mem_wr_o, .mem_ok_i
    );

    dcache_resp i_resp (
        .clk, .rst,
        .sel_i         (sel),
        .fire_i        (fire),
        .way0_data_i   (data0),
        .way1_data_i   (data1),
        .mem_rdata_i,
        .wdata_i       (lk.wdata),
        .mask_i        (lk.mask),
        .merged_o      (merged),
        .victim_data_o (victim_data),
        .rdata_o, .done_o
    );

    dcache_sram #(.entry_t(logic [TAG_W-1:0]), .INDEX_W(INDEX_W)) i_tag0 (
        .clk, .rd_index_i (lk.index), .rdata_o (tag0),
        .we_i (tag_we0), .wr_index_i (wr_index), .wdata_i (wr_tag)
    );

    dcache_sram #(.entry_t(logic [TAG_W-1:0]), .INDEX_W(INDEX_W)) i_tag1 (
        .clk, .rd_index_i (lk.index), .rdata_o (tag1),
        .we_i (tag_we1), .wr_index_i (wr_index), .wdata_i (wr_tag)
    );

    dcache_sram #(.entry_t(dcache_geom_pkg::word_t), .INDEX_W(INDEX_W)) i_data0 (
        .clk, .rd_index_i (lk.index), .rdata_o (data0),
        .we_i (data_we0), .wr_index_i (wr_index), .wdata_i (merged)
    );

    dcache_sram #(.entry_t(dcache_geom_pkg::word_t), .INDEX_W(INDEX_W)) i_data1 (
        .clk, .rd_index_i (lk.index), .rdata_o (data1),
        .we_i (data_we1), .wr_index_i (wr_index), .wdata_i (merged)
    );

endmodule

`default_nettype wire

/* tb/dcache_tb.sv */
// testbench top
// DUT, clock, checker, backing memory with random answer delay
// directed tests, then random loads and stores, cycle limit

`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int INDEX_W     = dcache_geom_pkg::INDEX_W_DEFAULT;
    localparam int TAG_W       = dcache_geom_pkg::ADDR_W - INDEX_W - dcache_geom_pkg::OFFSET_W;
    localparam int RANDOM_OPS  = 300;
    localparam int CYCLE_LIMIT = RANDOM_OPS * 24 + 200;

    logic                   clk;
    logic                   rst;
    logic                   mem_rd_i;
    logic                   mem_wr_i;
    logic [63:0]            addr_i;
    dcache_geom_pkg::word_t wdata_i;
    dcache_geom_pkg::mask_t mask_i;
    dcache_geom_pkg::word_t rdata_o;
    logic                   done_o;
    logic                   mem_rd_o;
    logic                   mem_wr_o;
    logic [63:0]            mem_addr_o;
    dcache_geom_pkg::word_t mem_wdata_o;
    dcache_geom_pkg::word_t mem_rdata_i;
    logic                   mem_ok_i;

    int          errors;
    int          checks;
    int          tests;
    int          cycles = 0;
    logic [63:0] rng;
    logic [63:0] store_addr [$];
    logic [63:0] store_data [$];
    logic        mem_busy = 1'b0;
    int          mem_wait = 0;

    dcache_tb_clk i_clk (.clk_o (clk), .rst_o (rst));

    dcache_top #(.INDEX_W(INDEX_W)) i_dcache_top (
        .clk, .rst, .mem_rd_i, .mem_wr_i, .addr_i, .wdata_i, .mask_i, .rdata_o, .done_o,
        .mem_rd_o, .mem_wr_o, .mem_addr_o, .mem_wdata_o, .mem_rdata_i, .mem_ok_i
    );

    dcache_tb_check #(.INDEX_W(INDEX_W)) i_check (
        .clk, .rst,
        .core_rd_i (mem_rd_i), .core_wr_i (mem_wr_i), .core_addr_i (addr_i),
        .core_wdata_i (wdata_i), .core_mask_i (mask_i), .core_rdata_i (rdata_o),
        .core_done_i (done_o),
        .mem_rd_i (mem_rd_o), .mem_wr_i (mem_wr_o), .mem_addr_i (mem_addr_o),
        .mem_wdata_i (mem_wdata_o), .mem_ok_i,
        .errors_o (errors), .checks_o (checks), .tests_o (tests)
    );

    function automatic logic [63:0] xorshift64(input logic [63:0] s);
        logic [63:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    function automatic logic [63:0] store_read(input logic [63:0] a);
        for (int i = 0; i < store_addr.size(); i++) begin
            if (store_addr[i] == a) return store_data[i];
        end
        return i_check.mem_fill(a);
    endfunction

    function automatic void store_write(input logic [63:0] a, input logic [63:0] w);
        for (int i = 0; i < store_addr.size(); i++) begin
            if (store_addr[i] == a) begin
                store_data[i] = w;
                return;
            end
        end
        store_addr.push_back(a);
        store_data.push_back(w);
    endfunction

    function automatic logic [63:0] line_addr(input logic [TAG_W-1:0] tg,
                                              input logic [INDEX_W-1:0] idx);
        return {tg, idx, 3'b000};
    endfunction

    // 4 tags over 4 sets, random byte offset
    function automatic logic [63:0] pool_addr(input logic [63:0] r);
        logic [TAG_W-1:0]   tg;
        logic [INDEX_W-1:0] idx;
        case (r[1:0])
            2'd0:    tg = 'h3;
            2'd1:    tg = 'h11;
            2'd2:    tg = '1;
            default: tg = 'h7A5;
        endcase
        case (r[3:2])
            2'd0:    idx = 'd2;
            2'd1:    idx = 'd5;
            2'd2:    idx = 'd9;
            default: idx = '1;
        endcase
        return {tg, idx, r[6:4]};
    endfunction

    // memory answers each strobe after 1 to 4 cycles
    always @(posedge clk) begin
        mem_ok_i <= 1'b0;
        if (mem_busy) begin
            mem_wait--;
            if (mem_wait == 0) begin
                mem_busy = 1'b0;
                mem_ok_i <= 1'b1;
                if (mem_wr_o) begin
                    store_write(mem_addr_o, mem_wdata_o);
                end else begin
                    mem_rdata_i <= store_read(mem_addr_o);
                end
            end
        end else if ((mem_rd_o || mem_wr_o) && !mem_ok_i) begin
            rng      = xorshift64(rng);
            mem_wait = 1 + int'(rng % 4);
            mem_busy = 1'b1;
        end
    end

    task automatic core_access(input logic st, input logic [63:0] a,
                               input logic [63:0] w, input logic [7:0] m);
        mem_rd_i <= !st;
        mem_wr_i <= st;
        addr_i   <= a;
        wdata_i  <= w;
        mask_i   <= m;
        do begin
            @(posedge clk);
        end while (!done_o);
        mem_rd_i <= 1'b0;
        mem_wr_i <= 1'b0;
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        logic [63:0] a;
        logic [63:0] w;
        mem_rd_i    = 1'b0;
        mem_wr_i    = 1'b0;
        addr_i      = '0;
        wdata_i     = '0;
        mask_i      = '0;
        mem_rdata_i = '0;
        mem_ok_i    = 1'b0;
        rng         = 64'd25751;
        @(posedge rst);
        repeat (3) @(posedge clk);
        i_check.end_test("reset values");

        // unaligned load, refill must be word aligned
        core_access(1'b0, line_addr('h21, 'd1) + 64'h4, '0, '0);
        i_check.end_test("load miss, cold set");
        core_access(1'b0, line_addr('h21, 'd1), '0, '0);
        i_check.end_test("load hit");
        core_access(1'b1, line_addr('h21, 'd1), 64'h1122_3344_5566_7788, 8'b1010_0110);
        core_access(1'b0, line_addr('h21, 'd1), '0, '0);
        i_check.end_test("masked store, then load");
        core_access(1'b1, line_addr('h31, 'd5), 64'hA5A5_0000_1111_2222, 8'hFF);
        core_access(1'b1, line_addr('h32, 'd5), 64'h5A5A_3333_4444_5555, 8'h0F);
        core_access(1'b1, line_addr('h33, 'd5), 64'hC3C3_6666_7777_8888, 8'hF0);
        i_check.end_test("three stores in one set");

        for (int n = 0; n < RANDOM_OPS; n++) begin
            rng = xorshift64(rng);
            a   = pool_addr(rng);
            rng = xorshift64(rng);
            w   = rng;
            rng = xorshift64(rng);
            core_access(rng[0], a, w, rng[15:8]);
        end
        i_check.end_test("random loads and stores");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/dcache_tb_check.sv */
// cache checker
// reference model of tags, valid, dirty and recency per set
// shadow of memory contents as the core sees them
// compares every done pulse and every memory transfer

`timescale 1ns/1ps
`default_nettype none

module dcache_tb_check #(
    parameter int INDEX_W = dcache_geom_pkg::INDEX_W_DEFAULT
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        core_rd_i,
    input  wire logic        core_wr_i,
    input  wire logic [63:0] core_addr_i,
    input  wire logic [63:0] core_wdata_i,
    input  wire logic [7:0]  core_mask_i,
    input  wire logic [63:0] core_rdata_i,
    input  wire logic        core_done_i,
    input  wire logic        mem_rd_i,
    input  wire logic        mem_wr_i,
    input  wire logic [63:0] mem_addr_i,
    input  wire logic [63:0] mem_wdata_i,
    input  wire logic        mem_ok_i,
    output int               errors_o,
    output int               checks_o,
    output int               tests_o
);

    localparam int SETS  = 2 ** INDEX_W;
    localparam int TAG_W = dcache_geom_pkg::ADDR_W - INDEX_W - dcache_geom_pkg::OFFSET_W;

    logic             m_valid [SETS][2];
    logic             m_dirty [SETS][2];
    logic [TAG_W-1:0] m_tag   [SETS][2];
    // way to evict next
    logic             m_evict [SETS];
    logic [63:0]      shadow_addr [$];
    logic [63:0]      shadow_data [$];

    logic        exp_hit;
    logic        exp_wb;
    logic        exp_rd;
    logic [63:0] exp_wb_addr;
    logic [63:0] exp_wb_data;
    logic [63:0] exp_rd_addr;
    logic [63:0] exp_rdata;
    logic [63:0] op_addr;
    logic        op_store;
    logic        in_op = 1'b0;
    logic        wb_seen;
    logic        rd_seen;
    logic        prev_rst = 1'b0;
    int          edge_count = 0;
    int          start_edge;
    int          test_ops = 0;
    int          test_wbacks = 0;
    int          test_errors = 0;

    initial begin
        errors_o = 0;
        checks_o = 0;
        tests_o  = 0;
        for (int s = 0; s < SETS; s++) begin
            m_valid[s] = '{1'b0, 1'b0};
            m_dirty[s] = '{1'b0, 1'b0};
            m_evict[s] = 1'b0;
        end
    end

    // never-written words, built from the whole address
    function automatic logic [63:0] mem_fill(input logic [63:0] a);
        return (a * 64'h9E37_79B9_7F4A_7C15) ^ {a[31:0], a[63:32]};
    endfunction

    function automatic logic [63:0] shadow_read(input logic [63:0] a);
        for (int i = 0; i < shadow_addr.size(); i++) begin
            if (shadow_addr[i] == a) return shadow_data[i];
        end
        return mem_fill(a);
    endfunction

    function automatic void shadow_write(input logic [63:0] a, input logic [63:0] w);
        for (int i = 0; i < shadow_addr.size(); i++) begin
            if (shadow_addr[i] == a) begin
                shadow_data[i] = w;
                return;
            end
        end
        shadow_addr.push_back(a);
        shadow_data.push_back(w);
    endfunction

    // expected response word; sets the expected memory transfers
    function automatic logic [63:0] ref_access(input logic st, input logic [63:0] a,
                                               input logic [63:0] wd, input logic [7:0] m);
        logic [63:0]        aa;
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tg;
        logic [63:0]        w;
        int                 way;
        aa      = {a[63:3], 3'b000};
        idx     = aa[dcache_geom_pkg::OFFSET_W +: INDEX_W];
        tg      = aa[63 -: TAG_W];
        exp_hit = 1'b1;
        exp_wb  = 1'b0;
        exp_rd  = 1'b0;
        if (m_valid[idx][0] && m_tag[idx][0] == tg) begin
            way = 0;
        end else if (m_valid[idx][1] && m_tag[idx][1] == tg) begin
            way = 1;
        end else begin
            exp_hit = 1'b0;
            // empty way first, else the recency choice
            if (!m_valid[idx][0]) begin
                way = 0;
            end else if (!m_valid[idx][1]) begin
                way = 1;
            end else begin
                way = m_evict[idx];
            end
            if (m_valid[idx][way] && m_dirty[idx][way]) begin
                exp_wb      = 1'b1;
                exp_wb_addr = {m_tag[idx][way], idx, 3'b000};
                exp_wb_data = shadow_read(exp_wb_addr);
            end
            exp_rd           = 1'b1;
            exp_rd_addr      = aa;
            m_valid[idx][way] = 1'b1;
            m_tag[idx][way]   = tg;
            m_dirty[idx][way] = 1'b0;
        end
        w = shadow_read(aa);
        if (st) begin
            for (int b = 0; b < dcache_geom_pkg::MASK_W; b++) begin
                if (m[b]) w[8*b +: 8] = wd[8*b +: 8];
            end
            shadow_write(aa, w);
            m_dirty[idx][way] = 1'b1;
        end
        m_evict[idx] = (way == 0);
        return w;
    endfunction

    task automatic verify(input logic ok, input string msg);
        checks_o++;
        if (ok !== 1'b1) begin
            errors_o++;
            test_errors++;
            $display("FAIL %0t ns: %s", $time, msg);
        end
    endtask

    task automatic end_test(input string name);
        tests_o++;
        $display("test %0d, %s: %0d ops, %0d write-backs, %0d errors",
                 tests_o, name, test_ops, test_wbacks, test_errors);
        test_ops    = 0;
        test_wbacks = 0;
        test_errors = 0;
    endtask

    always @(posedge clk) begin
        edge_count++;
        if (!rst) begin
            in_op = 1'b0;
        end else begin
            if (!prev_rst) begin
                verify(core_done_i === 1'b0 && mem_rd_i === 1'b0 && mem_wr_i === 1'b0
                       && core_rdata_i === 64'd0, "outputs not idle after reset");
            end
            verify(!(mem_rd_i && mem_wr_i), "memory read and write strobes high together");
            // a strobe is only legal while the model waits for that transfer
            verify(!mem_wr_i || (in_op && exp_wb && !wb_seen),
                   "write-back strobe the model does not expect");
            verify(!mem_rd_i || (in_op && exp_rd && !rd_seen && wb_seen == exp_wb),
                   "refill strobe the model does not expect");
            if (mem_ok_i && mem_wr_i) begin
                verify(in_op && exp_wb && !wb_seen, "write-back the model does not expect");
                verify(mem_addr_i === exp_wb_addr, $sformatf("write-back address %h, expected %h",
                       mem_addr_i, exp_wb_addr));
                verify(mem_wdata_i === exp_wb_data, $sformatf("write-back data %h, expected %h",
                       mem_wdata_i, exp_wb_data));
                wb_seen = 1'b1;
                test_wbacks++;
            end
            if (mem_ok_i && mem_rd_i) begin
                verify(in_op && exp_rd && !rd_seen && wb_seen == exp_wb,
                       "refill the model does not expect");
                verify(mem_addr_i === exp_rd_addr, $sformatf("refill address %h, expected %h",
                       mem_addr_i, exp_rd_addr));
                rd_seen = 1'b1;
            end
            if (core_done_i) begin
                verify(in_op, "done_o pulse without a request");
                if (in_op) begin
                    verify(core_rdata_i === exp_rdata, $sformatf("%s %h returned %h, expected %h",
                           op_store ? "store" : "load", op_addr, core_rdata_i, exp_rdata));
                    if (exp_hit) begin
                        verify(edge_count - start_edge == 3, $sformatf(
                               "hit at %h done after %0d edges, expected 3",
                               op_addr, edge_count - start_edge));
                    end
                    verify(wb_seen == exp_wb && rd_seen == exp_rd,
                           $sformatf("memory transfers for %h differ from the model", op_addr));
                    test_ops++;
                end
                in_op = 1'b0;
            end else if ((core_rd_i || core_wr_i) && !in_op) begin
                op_store   = core_wr_i;
                op_addr    = core_addr_i;
                exp_rdata  = ref_access(core_wr_i, core_addr_i, core_wdata_i, core_mask_i);
                start_edge = edge_count;
                wb_seen    = 1'b0;
                rd_seen    = 1'b0;
                in_op      = 1'b1;
            end
        end
        prev_rst = rst;
    end

endmodule

`default_nettype wire

/* tb/dcache_tb_clk.sv */
// testbench clock and reset
// 10 ns clock, active-low reset held for 10 cycles

`timescale 1ns/1ps
`default_nettype none

module dcache_tb_clk (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // low from time zero, so the only rising edge is the release
    initial begin
        rst_o = 1'b0;
        repeat (10) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

`default_nettype wire
